// ==== filelist.f ====
+incdir+.
io_pkg.sv
byte_lane_if.sv
block_register.sv
block_datapath.sv
io_sequencer.sv
aes_host_io.sv
tb_aes_host_io.sv

// ==== Bender.yml ====
package:
  name: aes_host_io

sources:
  - io_pkg.sv
  - byte_lane_if.sv
  - block_register.sv
  - block_datapath.sv
  - io_sequencer.sv
  - aes_host_io.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_aes_host_io.sv

// ==== tb_host_tasks.svh ====
// Host-side protocol tasks and LFSR random source for the AES host link testbench
`ifndef TB_HOST_TASKS_SVH
`define TB_HOST_TASKS_SVH

// Fibonacci LFSR, taps 32 22 2 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
  logic fb;
  fb = state[31] ^ state[21] ^ state[1] ^ state[0];
  return {state[30:0], fb};
endfunction

// One LFSR step for every bit taken
task automatic take_random(input int nbits, output logic [127:0] bits);
  bits = '0;
  for (int i = 0; i < nbits; i++) begin
    lfsr_state = lfsr_next(lfsr_state);
    bits = {bits[126:0], lfsr_state[0]};
  end
endtask

// Steps falling edges until the device shows the wanted status
task automatic wait_status(input logic [1:0] status);
  @(negedge clk);
  while (to_sw_sig !== status) begin
    @(negedge clk);
  end
endtask

// Sends a block MSB first; called on a falling edge with the device idle
task automatic send_block(input logic [1:0]   start_cmd,
                          input logic [1:0]   fwd_cmd,
                          input logic [1:0]   next_cmd,
                          input logic [1:0]   end_cmd,
                          input logic [127:0] data);
  to_hw_sig = start_cmd;
  for (int i = 0; i < io_pkg::NUM_BYTES; i++) begin
    wait_status(io_pkg::STAT_BYTE);
    to_hw_port = data[127 - 8 * i -: 8];
    to_hw_sig  = fwd_cmd;
    wait_status(io_pkg::STAT_IDLE);
    to_hw_sig  = (i == io_pkg::NUM_BYTES - 1) ? end_cmd : next_cmd;
  end
  // End code is seen, drop it before idle reads it as a new command
  @(negedge clk);
  to_hw_sig  = io_pkg::HOST_IDLE;
  to_hw_port = '0;
endtask

// Collects the result bytes and the lane value at every acknowledge
task automatic read_result(output logic [127:0] shown, output logic [7:0] ack_bits);
  shown    = '0;
  ack_bits = '0;
  to_hw_sig = io_pkg::HOST_A;
  for (int i = 0; i < io_pkg::NUM_BYTES; i++) begin
    wait_status(io_pkg::STAT_BYTE);
    shown = {shown[119:0], to_sw_port};
    to_hw_sig = io_pkg::HOST_B;
    wait_status(io_pkg::STAT_IDLE);
    ack_bits  = ack_bits | to_sw_port;
    to_hw_sig = io_pkg::HOST_A;
  end
  @(negedge clk);
  to_hw_sig = io_pkg::HOST_IDLE;
endtask

`endif

// ==== tb_aes_host_io.sv ====
// Testbench for the AES host byte link covering reset, loads, run and result return
`timescale 1ns/100ps

module tb_aes_host_io;

  localparam int SEED            = 73299;
  localparam int NUM_XFERS       = 6;
  localparam int CYCLES_PER_BYTE = 4;
  localparam int XFER_CYCLES     = NUM_XFERS * io_pkg::NUM_BYTES * CYCLES_PER_BYTE;
  // Five times the transfer length, plus reset and back-pressure slack
  localparam int TIMEOUT_CYCLES  = 5 * XFER_CYCLES + 80;

  logic           clk;
  logic           reset_n;
  logic [1:0]     to_hw_sig;
  io_pkg::byte_t  to_hw_port;
  io_pkg::block_t msg_de;
  logic           aes_ready;
  logic [1:0]     to_sw_sig;
  io_pkg::byte_t  to_sw_port;
  io_pkg::block_t msg_en;
  io_pkg::block_t key;
  logic           io_ready;

  logic [31:0]    lfsr_state;
  int             err_cnt;
  int             test_errs;
  int             tests_run;
  int             tests_failed;
  string          test_name;

  `include "tb_host_tasks.svh"

  aes_host_io dut0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_sig  (to_hw_sig),
    .to_hw_port (to_hw_port),
    .msg_de     (msg_de),
    .aes_ready  (aes_ready),
    .to_sw_sig  (to_sw_sig),
    .to_sw_port (to_sw_port),
    .msg_en     (msg_en),
    .key        (key),
    .io_ready   (io_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Status right after reset release, then idle one cycle later
  a_reset_first: assert property (@(posedge clk) $rose(reset_n) |-> to_sw_sig == 2'd3)
    else begin
      $display("[FAIL] to_sw_sig: got %0h expected 3", $sampled(to_sw_sig));
      err_cnt++;
    end

  a_reset_next: assert property (@(posedge clk) $rose(reset_n) |=> to_sw_sig == 2'd0)
    else begin
      $display("[FAIL] to_sw_sig: got %0h expected 0", $sampled(to_sw_sig));
      err_cnt++;
    end

  // Result lane is quiet outside a byte step
  a_quiet_port: assert property (@(posedge clk) disable iff (!reset_n)
    (to_sw_sig != io_pkg::STAT_BYTE) |-> (to_sw_port == '0))
    else begin
      $display("[FAIL] to_sw_port: got %0h expected 0", $sampled(to_sw_port));
      err_cnt++;
    end

  a_run_hold: assert property (@(posedge clk) disable iff (!reset_n)
    (io_ready && !aes_ready) |=> io_ready)
    else begin
      $display("[FAIL] io_ready: got %0h expected 1", $sampled(io_ready));
      err_cnt++;
    end

  a_run_exit: assert property (@(posedge clk) disable iff (!reset_n)
    (io_ready && aes_ready) |=> (!io_ready && to_sw_sig == io_pkg::STAT_DONE))
    else begin
      $display("[FAIL] io_ready: got %0h expected 0, to_sw_sig: got %0h expected 2",
               $sampled(io_ready), $sampled(to_sw_sig));
      err_cnt++;
    end

  task automatic check_eq(input string name, input logic [127:0] got,
                          input logic [127:0] expected);
    assert (got === expected) else begin
      $display("[FAIL] %s: got %0h expected %0h", name, got, expected);
      err_cnt++;
    end
  endtask

  task automatic open_test(input string name);
    test_name = name;
    test_errs = err_cnt;
  endtask

  task automatic close_test();
    tests_run++;
    if (err_cnt == test_errs) begin
      $display("test %0d %s: ok", tests_run, test_name);
    end else begin
      tests_failed++;
      $display("test %0d %s: %0d errors", tests_run, test_name, err_cnt - test_errs);
    end
  endtask

  initial begin : main_seq
    logic [127:0] rnd;
    logic [127:0] exp_msg;
    logic [127:0] exp_key;
    logic [127:0] first_msg;
    logic [127:0] got;
    logic [7:0]   ack_or;
    int           hold;

    reset_n      = 1'b0;
    to_hw_sig    = io_pkg::HOST_IDLE;
    to_hw_port   = '0;
    msg_de       = '0;
    aes_ready    = 1'b0;
    lfsr_state   = SEED;
    err_cnt      = 0;
    tests_run    = 0;
    tests_failed = 0;

    open_test("reset state");
    repeat (5) @(negedge clk);
    reset_n = 1'b1;
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_RESET);
    @(negedge clk);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    check_eq("io_ready", io_ready, 0);
    check_eq("to_sw_port", to_sw_port, 0);
    check_eq("msg_en", msg_en, 0);
    check_eq("key", key, 0);
    close_test();

    open_test("message load");
    take_random(128, rnd);
    exp_msg = rnd;
    send_block(io_pkg::HOST_A, io_pkg::HOST_B, io_pkg::HOST_A, io_pkg::HOST_IDLE, exp_msg);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    check_eq("msg_en", msg_en, exp_msg);
    check_eq("key", key, 0);
    close_test();

    open_test("key load");
    take_random(128, rnd);
    exp_key = rnd;
    send_block(io_pkg::HOST_B, io_pkg::HOST_A, io_pkg::HOST_B, io_pkg::HOST_RUN, exp_key);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    check_eq("key", key, exp_key);
    check_eq("msg_en", msg_en, exp_msg);
    close_test();

    open_test("run with back-pressure");
    take_random(5, rnd);
    hold = int'(rnd % 20) + 1;
    to_hw_sig = io_pkg::HOST_RUN;
    for (int k = 0; k < hold; k++) begin
      @(negedge clk);
      to_hw_sig = io_pkg::HOST_IDLE;
      check_eq("io_ready", io_ready, 1);
    end
    aes_ready = 1'b1;
    @(negedge clk);
    aes_ready = 1'b0;
    check_eq("io_ready", io_ready, 0);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_DONE);
    close_test();

    open_test("result return");
    take_random(128, rnd);
    msg_de = rnd;
    read_result(got, ack_or);
    check_eq("to_sw_port", got, msg_de);
    check_eq("to_sw_port", ack_or, 0);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    close_test();

    open_test("message reload");
    take_random(128, rnd);
    first_msg = rnd;
    send_block(io_pkg::HOST_A, io_pkg::HOST_B, io_pkg::HOST_A, io_pkg::HOST_IDLE, first_msg);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    check_eq("msg_en", msg_en, first_msg);
    take_random(128, rnd);
    exp_msg = rnd;
    send_block(io_pkg::HOST_A, io_pkg::HOST_B, io_pkg::HOST_A, io_pkg::HOST_IDLE, exp_msg);
    check_eq("to_sw_sig", to_sw_sig, io_pkg::STAT_IDLE);
    check_eq("msg_en", msg_en, exp_msg);
    check_eq("key", key, exp_key);
    close_test();

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

  initial begin : watchdog
    int cycle_cnt;
    cycle_cnt = 0;
    while (cycle_cnt < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles while running test %s", TIMEOUT_CYCLES, test_name);
    $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== aes_host_io.sv ====
// Host byte link top joining the protocol sequencer and block datapath
`timescale 1ns/100ps

module aes_host_io (
  input  logic           clk,
  input  logic           reset_n,
  input  logic [1:0]     to_hw_sig,
  input  io_pkg::byte_t  to_hw_port,
  input  io_pkg::block_t msg_de,
  input  logic           aes_ready,
  output logic [1:0]     to_sw_sig,
  output io_pkg::byte_t  to_sw_port,
  output io_pkg::block_t msg_en,
  output io_pkg::block_t key,
  output logic           io_ready
);

  io_pkg::host_cmd_t host_cmd;
  io_pkg::dev_stat_t dev_stat;

  byte_lane_if lane ();

  // Raw host lines onto the typed codes
  assign host_cmd  = io_pkg::host_cmd_t'(to_hw_sig);
  assign to_sw_sig = dev_stat;

  io_sequencer seq0 (
    .clk       (clk),
    .reset_n   (reset_n),
    .to_hw_sig (host_cmd),
    .aes_ready (aes_ready),
    .to_sw_sig (dev_stat),
    .io_ready  (io_ready),
    .lane      (lane.ctrl)
  );

  block_datapath dp0 (
    .clk        (clk),
    .reset_n    (reset_n),
    .to_hw_port (to_hw_port),
    .msg_de     (msg_de),
    .lane       (lane.data),
    .msg_en     (msg_en),
    .key        (key),
    .to_sw_port (to_sw_port)
  );

endmodule

// ==== io_sequencer.sv ====
// Host protocol sequencer with phase FSM, handshake half-step and byte counter
`timescale 1ns/100ps

module io_sequencer (
  input  logic              clk,
  input  logic              reset_n,
  input  io_pkg::host_cmd_t to_hw_sig,
  input  logic              aes_ready,
  output io_pkg::dev_stat_t to_sw_sig,
  output logic              io_ready,
  byte_lane_if.ctrl         lane
);

  typedef enum logic [2:0] {
    PH_RESET,
    PH_IDLE,
    PH_LOAD_MSG,
    PH_LOAD_KEY,
    PH_RUN,
    PH_DONE,
    PH_UNLOAD
  } phase_t;

  phase_t            phase;
  phase_t            phase_nxt;
  logic              ack;
  logic              ack_nxt;
  io_pkg::byte_idx_t byte_cnt;
  io_pkg::byte_idx_t byte_cnt_nxt;
  logic              last_byte;

  // Expected host codes for the current transfer phase
  io_pkg::host_cmd_t fwd_code;
  io_pkg::host_cmd_t next_code;
  io_pkg::host_cmd_t end_code;

  assign last_byte = (byte_cnt == io_pkg::byte_idx_t'(io_pkg::NUM_BYTES - 1));

  always_comb begin
    case (phase)
      PH_LOAD_KEY: begin
        fwd_code  = io_pkg::HOST_A;
        next_code = io_pkg::HOST_B;
        end_code  = io_pkg::HOST_RUN;
      end
      PH_UNLOAD: begin
        fwd_code  = io_pkg::HOST_B;
        next_code = io_pkg::HOST_A;
        end_code  = io_pkg::HOST_A;
      end
      default: begin
        // Message load codes
        fwd_code  = io_pkg::HOST_B;
        next_code = io_pkg::HOST_A;
        end_code  = io_pkg::HOST_IDLE;
      end
    endcase
  end

  always_comb begin
    phase_nxt    = phase;
    ack_nxt      = ack;
    byte_cnt_nxt = byte_cnt;

    case (phase)
      PH_RESET: begin
        phase_nxt = PH_IDLE;
      end

      PH_IDLE: begin
        ack_nxt      = 1'b0;
        byte_cnt_nxt = '0;
        case (to_hw_sig)
          io_pkg::HOST_A:   phase_nxt = PH_LOAD_MSG;
          io_pkg::HOST_B:   phase_nxt = PH_LOAD_KEY;
          io_pkg::HOST_RUN: phase_nxt = PH_RUN;
          default:          phase_nxt = PH_IDLE;
        endcase
      end

      // Core holds us here as long as it needs
      PH_RUN: begin
        if (aes_ready) begin
          phase_nxt = PH_DONE;
        end
      end

      PH_DONE: begin
        if (to_hw_sig == io_pkg::HOST_A) begin
          phase_nxt    = PH_UNLOAD;
          ack_nxt      = 1'b0;
          byte_cnt_nxt = '0;
        end
      end

      // Load message, load key and unload share the byte/ack stepping
      default: begin
        if (!ack) begin
          if (to_hw_sig == fwd_code) begin
            ack_nxt = 1'b1;
          end
        end else if (last_byte) begin
          if (to_hw_sig == end_code) begin
            phase_nxt = PH_IDLE;
          end
        end else if (to_hw_sig == next_code) begin
          ack_nxt      = 1'b0;
          byte_cnt_nxt = byte_cnt + 1'b1;
        end
      end
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      phase    <= PH_RESET;
      ack      <= 1'b0;
      byte_cnt <= '0;
    end else begin
      phase    <= phase_nxt;
      ack      <= ack_nxt;
      byte_cnt <= byte_cnt_nxt;
    end
  end

  // Status decode
  always_comb begin
    case (phase)
      PH_RESET:    to_sw_sig = io_pkg::STAT_RESET;
      PH_DONE:     to_sw_sig = io_pkg::STAT_DONE;
      PH_LOAD_MSG,
      PH_LOAD_KEY,
      PH_UNLOAD:   to_sw_sig = ack ? io_pkg::STAT_IDLE : io_pkg::STAT_BYTE;
      default:     to_sw_sig = io_pkg::STAT_IDLE;
    endcase
  end

  assign io_ready = (phase == PH_RUN);

  // Byte lane controls, only during the byte half-step
  assign lane.load_msg = (phase == PH_LOAD_MSG) && !ack;
  assign lane.load_key = (phase == PH_LOAD_KEY) && !ack;
  assign lane.unload   = (phase == PH_UNLOAD) && !ack;
  assign lane.byte_idx = byte_cnt;

endmodule

// ==== block_datapath.sv ====
// Message and key block storage plus result byte select toward the host
`timescale 1ns/100ps

module block_datapath (
  input  logic           clk,
  input  logic           reset_n,
  input  io_pkg::byte_t  to_hw_port,
  input  io_pkg::block_t msg_de,
  byte_lane_if.data      lane,
  output io_pkg::block_t msg_en,
  output io_pkg::block_t key,
  output io_pkg::byte_t  to_sw_port
);

  block_register #(
    .payload_t (io_pkg::block_t)
  ) msg_reg (
    .clk      (clk),
    .reset_n  (reset_n),
    .wr_en    (lane.load_msg),
    .byte_idx (lane.byte_idx),
    .wr_byte  (to_hw_port),
    .block    (msg_en)
  );

  block_register #(
    .payload_t (io_pkg::block_t)
  ) key_reg (
    .clk      (clk),
    .reset_n  (reset_n),
    .wr_en    (lane.load_key),
    .byte_idx (lane.byte_idx),
    .wr_byte  (to_hw_port),
    .block    (key)
  );

  // Result byte only while presented, zero otherwise
  always_comb begin
    to_sw_port = '0;
    if (lane.unload) begin
      to_sw_port = msg_de[(io_pkg::NUM_BYTES - 1 - lane.byte_idx) * io_pkg::BYTE_BITS
                          +: io_pkg::BYTE_BITS];
    end
  end

endmodule

// ==== block_register.sv ====
// Block register loaded one byte slice per enabled cycle, index 0 at the top byte
`timescale 1ns/100ps

module block_register #(
  parameter type payload_t = io_pkg::block_t
) (
  input  logic              clk,
  input  logic              reset_n,
  input  logic              wr_en,
  input  io_pkg::byte_idx_t byte_idx,
  input  io_pkg::byte_t     wr_byte,
  output payload_t          block
);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block <= '0;
    end else if (wr_en) begin
      // Count slices down from the top so index 0 lands on the MSB
      block[($bits(payload_t) / io_pkg::BYTE_BITS - 1 - byte_idx) * io_pkg::BYTE_BITS
            +: io_pkg::BYTE_BITS] <= wr_byte;
    end
  end

endmodule

// ==== byte_lane_if.sv ====
// Byte lane controls passed from the host sequencer to the block datapath
`timescale 1ns/100ps

interface byte_lane_if;

  // Levels, high for the whole byte step
  logic load_msg;
  logic load_key;
  logic unload;

  io_pkg::byte_idx_t byte_idx;

  modport ctrl (
    output load_msg,
    output load_key,
    output unload,
    output byte_idx
  );

  modport data (
    input load_msg,
    input load_key,
    input unload,
    input byte_idx
  );

endinterface

// ==== io_pkg.sv ====
// AES host link package with lane widths, block types and host/device handshake codes
package io_pkg;

  localparam int BYTE_BITS  = 8;
  localparam int NUM_BYTES  = 16;
  localparam int BLOCK_BITS = BYTE_BITS * NUM_BYTES;

  typedef logic [BYTE_BITS-1:0] byte_t;

  // Message, key and result all share this width
  typedef logic [BLOCK_BITS-1:0] block_t;

  // Position 0 is the most significant byte of a block
  typedef logic [$clog2(NUM_BYTES)-1:0] byte_idx_t;

  // Codes the host drives on to_hw_sig
  typedef enum logic [1:0] {
    HOST_IDLE = 2'd0,
    HOST_A    = 2'd1,
    HOST_B    = 2'd2,
    HOST_RUN  = 2'd3
  } host_cmd_t;

  // Codes the device drives on to_sw_sig
  typedef enum logic [1:0] {
    STAT_IDLE  = 2'd0,
    STAT_BYTE  = 2'd1,
    STAT_DONE  = 2'd2,
    STAT_RESET = 2'd3
  } dev_stat_t;

endpackage
